//--- src/arcade_pkg.sv
package arcade_pkg;

  ////////////////////////////////////////
  // Word widths
  ////////////////////////////////////////

  localparam int PS2_W    = 11;
  localparam int JOY_W    = 32;
  localparam int CTRL_W   = 11;
  localparam int STATUS_W = 32;
  localparam int ARX_W    = 12;

  // PS/2 key word fields
  localparam int PS2_TOGGLE_BIT  = 10;
  localparam int PS2_PRESSED_BIT = 9;
  localparam int PS2_CODE_W      = 8;

  ////////////////////////////////////////
  // Scan codes
  ////////////////////////////////////////

  // Player 1
  localparam logic [PS2_CODE_W-1:0] KEY_UP    = 8'h75;
  localparam logic [PS2_CODE_W-1:0] KEY_DOWN  = 8'h72;
  localparam logic [PS2_CODE_W-1:0] KEY_LEFT  = 8'h6b;
  localparam logic [PS2_CODE_W-1:0] KEY_RIGHT = 8'h74;
  localparam logic [PS2_CODE_W-1:0] KEY_CTRL  = 8'h14;
  localparam logic [PS2_CODE_W-1:0] KEY_ALT   = 8'h11;
  localparam logic [PS2_CODE_W-1:0] KEY_SPACE = 8'h29;
  localparam logic [PS2_CODE_W-1:0] KEY_SHIFT = 8'h12;
  localparam logic [PS2_CODE_W-1:0] KEY_1     = 8'h16;
  localparam logic [PS2_CODE_W-1:0] KEY_5     = 8'h2e;
  localparam logic [PS2_CODE_W-1:0] KEY_P     = 8'h4d;

  // Player 2
  localparam logic [PS2_CODE_W-1:0] KEY_R     = 8'h2d;
  localparam logic [PS2_CODE_W-1:0] KEY_F     = 8'h2b;
  localparam logic [PS2_CODE_W-1:0] KEY_D     = 8'h23;
  localparam logic [PS2_CODE_W-1:0] KEY_G     = 8'h34;
  localparam logic [PS2_CODE_W-1:0] KEY_A     = 8'h1c;
  localparam logic [PS2_CODE_W-1:0] KEY_S     = 8'h1b;
  localparam logic [PS2_CODE_W-1:0] KEY_Q     = 8'h15;
  localparam logic [PS2_CODE_W-1:0] KEY_W     = 8'h1d;
  localparam logic [PS2_CODE_W-1:0] KEY_2     = 8'h1e;
  localparam logic [PS2_CODE_W-1:0] KEY_6     = 8'h36;

  // Held-key state vector, one bit per tracked key
  localparam int KEY_STATE_W = 21;
  localparam int KEY_IDX_W   = 5;

  // Bit index of each key in the state vector
  localparam int KI_UP    = 0;
  localparam int KI_DOWN  = 1;
  localparam int KI_LEFT  = 2;
  localparam int KI_RIGHT = 3;
  localparam int KI_CTRL  = 4;
  localparam int KI_ALT   = 5;
  localparam int KI_SPACE = 6;
  localparam int KI_SHIFT = 7;
  localparam int KI_1     = 8;
  localparam int KI_5     = 9;
  localparam int KI_P     = 10;
  localparam int KI_R     = 11;
  localparam int KI_F     = 12;
  localparam int KI_D     = 13;
  localparam int KI_G     = 14;
  localparam int KI_A     = 15;
  localparam int KI_S     = 16;
  localparam int KI_Q     = 17;
  localparam int KI_W     = 18;
  localparam int KI_2     = 19;
  localparam int KI_6     = 20;

  ////////////////////////////////////////
  // Control vector bits
  ////////////////////////////////////////

  // Same layout as the low joystick bits
  localparam int CTRL_RIGHT    = 0;
  localparam int CTRL_LEFT     = 1;
  localparam int CTRL_DOWN     = 2;
  localparam int CTRL_UP       = 3;
  localparam int CTRL_BUTTON_1 = 4;
  localparam int CTRL_BUTTON_2 = 5;
  localparam int CTRL_BUTTON_3 = 6;
  localparam int CTRL_BUTTON_4 = 7;
  localparam int CTRL_START    = 8;
  localparam int CTRL_COIN     = 9;
  localparam int CTRL_PAUSE    = 10;

  // PLL lock-loss reset stretch
  localparam int LOCK_RESET_CYCLES = 256;
  localparam int LOCK_CNT_W        = 8;

  ////////////////////////////////////////
  // Video options
  ////////////////////////////////////////

  localparam int ASPECT_W = 2;
  localparam int FX_W     = 3;
  localparam int SL_W     = 2;
  localparam logic [FX_W-1:0] FX_HQ2X = 3'd1;

  // Native 4:3 picture
  localparam int ASPECT_NATIVE_X = 4;
  localparam int ASPECT_NATIVE_Y = 3;

  // Option field positions in the status word
  localparam int STATUS_ASPECT_LSB = 1;
  localparam int STATUS_ORIENT_BIT = 3;
  localparam int STATUS_FX_LSB     = 5;

endpackage

//--- src/ps2_key_tracker.sv
module ps2_key_tracker (
  input  logic                               clk_sys,
  input  logic                               RESET,
  input  logic [arcade_pkg::PS2_W-1:0]       ps2_key,
  output logic [arcade_pkg::KEY_STATE_W-1:0] key_state
);

  import arcade_pkg::*;

  // Fields of the incoming key word
  logic [PS2_CODE_W-1:0] key_code;
  logic                  key_pressed;
  logic                  key_toggle;

  // Toggle value seen on the previous clock
  logic                  toggle_q;
  logic                  key_event;

  // Result of the scan code lookup
  logic [KEY_IDX_W-1:0]  key_idx;
  logic                  key_hit;

  assign key_code    = ps2_key[PS2_CODE_W-1:0];
  assign key_pressed = ps2_key[PS2_PRESSED_BIT];
  assign key_toggle  = ps2_key[PS2_TOGGLE_BIT];

  // One event per toggle flip
  assign key_event = key_toggle ^ toggle_q;

  ////////////////////////////////////////
  // Scan code to state index
  ////////////////////////////////////////

  always_comb begin
    key_hit = 1'b1;
    key_idx = '0;
    case (key_code)
      KEY_UP:    key_idx = KEY_IDX_W'(KI_UP);
      KEY_DOWN:  key_idx = KEY_IDX_W'(KI_DOWN);
      KEY_LEFT:  key_idx = KEY_IDX_W'(KI_LEFT);
      KEY_RIGHT: key_idx = KEY_IDX_W'(KI_RIGHT);
      KEY_CTRL:  key_idx = KEY_IDX_W'(KI_CTRL);
      KEY_ALT:   key_idx = KEY_IDX_W'(KI_ALT);
      KEY_SPACE: key_idx = KEY_IDX_W'(KI_SPACE);
      KEY_SHIFT: key_idx = KEY_IDX_W'(KI_SHIFT);
      KEY_1:     key_idx = KEY_IDX_W'(KI_1);
      KEY_5:     key_idx = KEY_IDX_W'(KI_5);
      KEY_P:     key_idx = KEY_IDX_W'(KI_P);
      KEY_R:     key_idx = KEY_IDX_W'(KI_R);
      KEY_F:     key_idx = KEY_IDX_W'(KI_F);
      KEY_D:     key_idx = KEY_IDX_W'(KI_D);
      KEY_G:     key_idx = KEY_IDX_W'(KI_G);
      KEY_A:     key_idx = KEY_IDX_W'(KI_A);
      KEY_S:     key_idx = KEY_IDX_W'(KI_S);
      KEY_Q:     key_idx = KEY_IDX_W'(KI_Q);
      KEY_W:     key_idx = KEY_IDX_W'(KI_W);
      KEY_2:     key_idx = KEY_IDX_W'(KI_2);
      KEY_6:     key_idx = KEY_IDX_W'(KI_6);
      // Untracked key
      default:   key_hit = 1'b0;
    endcase
  end

  // Held state follows the pressed bit of each event
  always_ff @(posedge clk_sys or posedge RESET) begin
    if (RESET) begin
      toggle_q  <= 1'b0;
      key_state <= '0;
    end else begin
      toggle_q <= key_toggle;
      if (key_event && key_hit) begin
        key_state[key_idx] <= key_pressed;
      end
    end
  end

endmodule

//--- src/player_merge.sv
module player_merge (
  input  logic                               clk_sys,
  input  logic                               RESET,
  input  logic [arcade_pkg::KEY_STATE_W-1:0] key_state,
  input  logic [arcade_pkg::JOY_W-1:0]       joystick_0,
  input  logic [arcade_pkg::JOY_W-1:0]       joystick_1,
  output logic [arcade_pkg::CTRL_W-1:0]      player_1_ctrl,
  output logic [arcade_pkg::CTRL_W-1:0]      player_2_ctrl
);

  import arcade_pkg::*;

  // Keys laid out as control vectors
  logic [CTRL_W-1:0] p1_keys;
  logic [CTRL_W-1:0] p2_keys;

  ////////////////////////////////////////
  // Key to control bit mapping
  ////////////////////////////////////////

  always_comb begin
    // Player 1 uses arrows and the left modifiers
    p1_keys                = '0;
    p1_keys[CTRL_RIGHT]    = key_state[KI_RIGHT];
    p1_keys[CTRL_LEFT]     = key_state[KI_LEFT];
    p1_keys[CTRL_DOWN]     = key_state[KI_DOWN];
    p1_keys[CTRL_UP]       = key_state[KI_UP];
    p1_keys[CTRL_BUTTON_1] = key_state[KI_CTRL];
    p1_keys[CTRL_BUTTON_2] = key_state[KI_ALT];
    p1_keys[CTRL_BUTTON_3] = key_state[KI_SPACE];
    p1_keys[CTRL_BUTTON_4] = key_state[KI_SHIFT];
    p1_keys[CTRL_START]    = key_state[KI_1];
    p1_keys[CTRL_COIN]     = key_state[KI_5];
    p1_keys[CTRL_PAUSE]    = key_state[KI_P];

    // Player 2 on the letter block, no pause key
    p2_keys                = '0;
    p2_keys[CTRL_RIGHT]    = key_state[KI_G];
    p2_keys[CTRL_LEFT]     = key_state[KI_D];
    p2_keys[CTRL_DOWN]     = key_state[KI_F];
    p2_keys[CTRL_UP]       = key_state[KI_R];
    p2_keys[CTRL_BUTTON_1] = key_state[KI_A];
    p2_keys[CTRL_BUTTON_2] = key_state[KI_S];
    p2_keys[CTRL_BUTTON_3] = key_state[KI_Q];
    p2_keys[CTRL_BUTTON_4] = key_state[KI_W];
    p2_keys[CTRL_START]    = key_state[KI_2];
    p2_keys[CTRL_COIN]     = key_state[KI_6];
  end

  // Keys OR joystick, one register stage
  always_ff @(posedge clk_sys or posedge RESET) begin
    if (RESET) begin
      player_1_ctrl <= '0;
      player_2_ctrl <= '0;
    end else begin
      player_1_ctrl <= p1_keys | joystick_0[CTRL_W-1:0];
      player_2_ctrl <= p2_keys | joystick_1[CTRL_W-1:0];
    end
  end

endmodule

//--- src/video_option_decode.sv
module video_option_decode (
  input  logic                            clk_sys,
  input  logic                            RESET,
  input  logic [arcade_pkg::ASPECT_W-1:0] aspect_ratio,
  input  logic                            orientation,
  input  logic [arcade_pkg::FX_W-1:0]     fx,
  input  logic                            forced_scandoubler,
  output logic [arcade_pkg::ARX_W-1:0]    video_arx,
  output logic [arcade_pkg::ARX_W-1:0]    video_ary,
  output logic [arcade_pkg::SL_W-1:0]     vga_sl,
  output logic                            scandoubler,
  output logic                            hq2x
);

  import arcade_pkg::*;

  // Next register values
  logic [ARX_W-1:0] arx_d;
  logic [ARX_W-1:0] ary_d;
  logic [FX_W-1:0]  fx_m1;
  logic [SL_W-1:0]  sl_d;
  logic             fx_on;

  ////////////////////////////////////////
  // Aspect ratio
  ////////////////////////////////////////

  always_comb begin
    if (aspect_ratio == '0) begin
      // Original picture, swapped when rotated
      arx_d = orientation ? ARX_W'(ASPECT_NATIVE_Y) : ARX_W'(ASPECT_NATIVE_X);
      ary_d = orientation ? ARX_W'(ASPECT_NATIVE_X) : ARX_W'(ASPECT_NATIVE_Y);
    end else begin
      // Fullscreen or custom ratio index
      arx_d = ARX_W'(aspect_ratio - ASPECT_W'(1));
      ary_d = '0;
    end
  end

  // Effect codes above HQ2x are scanline levels
  assign fx_on = (fx != '0);
  assign fx_m1 = fx - FX_W'(1);
  assign sl_d  = fx_on ? fx_m1[SL_W-1:0] : '0;

  // Reset value is the decode of an all-zero option word
  always_ff @(posedge clk_sys or posedge RESET) begin
    if (RESET) begin
      video_arx   <= ARX_W'(ASPECT_NATIVE_X);
      video_ary   <= ARX_W'(ASPECT_NATIVE_Y);
      vga_sl      <= '0;
      scandoubler <= 1'b0;
      hq2x        <= 1'b0;
    end else begin
      video_arx   <= arx_d;
      video_ary   <= ary_d;
      vga_sl      <= sl_d;
      scandoubler <= fx_on || forced_scandoubler;
      hq2x        <= (fx == FX_HQ2X);
    end
  end

endmodule

//--- src/lock_loss_reset.sv
module lock_loss_reset (
  input  logic clk_sys,
  input  logic RESET,
  input  logic pll_locked,
  output logic pll_reset
);

  import arcade_pkg::*;

  // Stretch counter start value
  localparam logic [LOCK_CNT_W-1:0] CNT_LOAD = LOCK_CNT_W'(LOCK_RESET_CYCLES - 1);

  logic                  locked_q;
  logic                  lock_fall;
  logic [LOCK_CNT_W-1:0] rst_cnt;

  // High to low on lock only, regain is ignored
  assign lock_fall = locked_q && !pll_locked;

  ////////////////////////////////////////
  // Reset stretch
  ////////////////////////////////////////

  always_ff @(posedge clk_sys or posedge RESET) begin
    if (RESET) begin
      locked_q  <= 1'b0;
      rst_cnt   <= '0;
      pll_reset <= 1'b0;
    end else begin
      locked_q <= pll_locked;
      if (lock_fall) begin
        // Restart the full stretch
        rst_cnt   <= CNT_LOAD;
        pll_reset <= 1'b1;
      end else if (rst_cnt != '0) begin
        rst_cnt <= rst_cnt - LOCK_CNT_W'(1);
      end else begin
        // Count exhausted
        pll_reset <= 1'b0;
      end
    end
  end

endmodule

//--- src/arcade_front_end.sv
module arcade_front_end (
  input  logic                            clk_sys,
  input  logic                            RESET,
  input  logic [arcade_pkg::PS2_W-1:0]    ps2_key,
  input  logic [arcade_pkg::JOY_W-1:0]    joystick_0,
  input  logic [arcade_pkg::JOY_W-1:0]    joystick_1,
  input  logic [arcade_pkg::STATUS_W-1:0] status,
  input  logic                            forced_scandoubler,
  input  logic                            pll_locked,
  output logic [arcade_pkg::CTRL_W-1:0]   player_1_ctrl,
  output logic [arcade_pkg::CTRL_W-1:0]   player_2_ctrl,
  output logic [arcade_pkg::ARX_W-1:0]    video_arx,
  output logic [arcade_pkg::ARX_W-1:0]    video_ary,
  output logic [arcade_pkg::SL_W-1:0]     vga_sl,
  output logic                            scandoubler,
  output logic                            hq2x,
  output logic                            pll_reset
);

  import arcade_pkg::*;

  logic [KEY_STATE_W-1:0] key_state;

  // Option fields of the status word
  logic [ASPECT_W-1:0]    aspect_ratio;
  logic                   orientation;
  logic [FX_W-1:0]        fx;

  assign aspect_ratio = status[STATUS_ASPECT_LSB +: ASPECT_W];
  assign orientation  = status[STATUS_ORIENT_BIT];
  assign fx           = status[STATUS_FX_LSB +: FX_W];

  ////////////////////////////////////////
  // Controls
  ////////////////////////////////////////

  ps2_key_tracker i_ps2_key_tracker (
    .clk_sys   (clk_sys),
    .RESET     (RESET),
    .ps2_key   (ps2_key),
    .key_state (key_state)
  );

  player_merge i_player_merge (
    .clk_sys       (clk_sys),
    .RESET         (RESET),
    .key_state     (key_state),
    .joystick_0    (joystick_0),
    .joystick_1    (joystick_1),
    .player_1_ctrl (player_1_ctrl),
    .player_2_ctrl (player_2_ctrl)
  );

  ////////////////////////////////////////
  // Video and clocking
  ////////////////////////////////////////

  video_option_decode i_video_option_decode (
    .clk_sys            (clk_sys),
    .RESET              (RESET),
    .aspect_ratio       (aspect_ratio),
    .orientation        (orientation),
    .fx                 (fx),
    .forced_scandoubler (forced_scandoubler),
    .video_arx          (video_arx),
    .video_ary          (video_ary),
    .vga_sl             (vga_sl),
    .scandoubler        (scandoubler),
    .hq2x               (hq2x)
  );

  // PLL reset on lock loss
  lock_loss_reset i_lock_loss_reset (
    .clk_sys    (clk_sys),
    .RESET      (RESET),
    .pll_locked (pll_locked),
    .pll_reset  (pll_reset)
  );

endmodule

//--- testbench/arcade_front_end_assertions.sv
module arcade_front_end_assertions (
  input logic clk_sys,
  input logic RESET,
  input logic pll_locked,
  input logic pll_reset
);
  timeunit 1ns;
  timeprecision 1ps;

  import arcade_pkg::*;

  // Consecutive cycles with pll_reset high
  int high_cnt;

  always_ff @(posedge clk_sys or posedge RESET) begin
    if (RESET) begin
      high_cnt <= 0;
    end else if (pll_reset) begin
      high_cnt <= high_cnt + 1;
    end else begin
      high_cnt <= 0;
    end
  end

  ////////////////////////////////////////
  // Lock-loss reset rules
  ////////////////////////////////////////

  a_low_in_reset: assert property (@(posedge clk_sys) RESET |-> !pll_reset)
    else $error("pll_reset high while RESET is asserted");

  // Rise one cycle after lock drops
  a_rise_on_fall: assert property (@(posedge clk_sys) disable iff (RESET)
    $fell(pll_locked) |=> pll_reset)
    else $error("pll_reset did not rise after lock fell");

  a_min_width: assert property (@(posedge clk_sys) disable iff (RESET)
    $fell(pll_reset) |-> high_cnt >= LOCK_RESET_CYCLES)
    else $error("pll_reset high for only %0d cycles", high_cnt);

endmodule

bind lock_loss_reset arcade_front_end_assertions i_lock_assertions (
  .clk_sys    (clk_sys),
  .RESET      (RESET),
  .pll_locked (pll_locked),
  .pll_reset  (pll_reset)
);

//--- testbench/arcade_front_end_tb.sv
module arcade_front_end_tb;
  timeunit 1ns;
  timeprecision 1ps;

  import arcade_pkg::*;

  localparam int RESET_CYCLES = 8;
  localparam int MARGIN_CYCLES = 400;
  localparam int LOCK_MAX_CYCLES = 260;

  // One row of stimulus and expected outputs
  typedef struct {
    string               name;
    logic [PS2_W-1:0]    ps2_word;
    logic [JOY_W-1:0]    joy_0;
    logic [JOY_W-1:0]    joy_1;
    logic [STATUS_W-1:0] status_word;
    logic                fsd;
    logic                locked;
    logic [CTRL_W-1:0]   exp_p1;
    logic [CTRL_W-1:0]   exp_p2;
    logic [ARX_W-1:0]    exp_arx;
    logic [ARX_W-1:0]    exp_ary;
    logic [SL_W-1:0]     exp_sl;
    logic                exp_sd;
    logic                exp_hq;
    int                  wait_cycles;
  } step_t;

  logic                clk_sys;
  logic                RESET;
  logic [PS2_W-1:0]    ps2_key;
  logic [JOY_W-1:0]    joystick_0;
  logic [JOY_W-1:0]    joystick_1;
  logic [STATUS_W-1:0] status;
  logic                forced_scandoubler;
  logic                pll_locked;
  logic [CTRL_W-1:0]   player_1_ctrl;
  logic [CTRL_W-1:0]   player_2_ctrl;
  logic [ARX_W-1:0]    video_arx;
  logic [ARX_W-1:0]    video_ary;
  logic [SL_W-1:0]     vga_sl;
  logic                scandoubler;
  logic                hq2x;
  logic                pll_reset;

  step_t steps[$];
  int    errors = 0;
  int    checks = 0;
  int    tests = 0;
  int    passed = 0;
  int    cycles = 0;
  int    cycle_limit = 100000;

  arcade_front_end i_arcade_front_end (.*);

  initial begin
    clk_sys = 1'b0;
    forever #5 clk_sys = ~clk_sys;
  end

  // Hang guard
  always @(posedge clk_sys) begin
    cycles++;
    if (cycles >= cycle_limit) begin
      $display("Timeout: run did not finish within %0d clock cycles", cycle_limit);
      $display("Simulation failed");
      $finish;
    end
  end

  ////////////////////////////////////////
  // Stimulus helpers
  ////////////////////////////////////////

  function automatic logic [PS2_W-1:0] key_word(input logic toggle, input logic pressed,
                                                input logic [PS2_CODE_W-1:0] code);
    logic [PS2_W-1:0] w;
    w = '0;
    w[PS2_TOGGLE_BIT] = toggle;
    w[PS2_PRESSED_BIT] = pressed;
    w[PS2_CODE_W-1:0] = code;
    return w;
  endfunction

  function automatic logic [CTRL_W-1:0] ctrl_bit(input int pos);
    logic [CTRL_W-1:0] v;
    v = '0;
    v[pos] = 1'b1;
    return v;
  endfunction

  // Option word from aspect, orientation and effect fields
  function automatic logic [STATUS_W-1:0] option_word(input logic [ASPECT_W-1:0] aspect,
                                                      input logic orient,
                                                      input logic [FX_W-1:0] effect);
    logic [STATUS_W-1:0] s;
    s = '0;
    s[STATUS_ASPECT_LSB +: ASPECT_W] = aspect;
    s[STATUS_ORIENT_BIT] = orient;
    s[STATUS_FX_LSB +: FX_W] = effect;
    return s;
  endfunction

  task automatic add_step(input string name, input logic [PS2_W-1:0] ps2_word,
                          input logic [JOY_W-1:0] joy_0, input logic [JOY_W-1:0] joy_1,
                          input logic [STATUS_W-1:0] status_word, input logic fsd,
                          input logic [CTRL_W-1:0] exp_p1, input logic [CTRL_W-1:0] exp_p2,
                          input logic [ARX_W-1:0] exp_arx, input logic [ARX_W-1:0] exp_ary,
                          input logic [SL_W-1:0] exp_sl, input logic exp_sd,
                          input logic exp_hq);
    step_t s;
    s.name = name;
    s.ps2_word = ps2_word;
    s.joy_0 = joy_0;
    s.joy_1 = joy_1;
    s.status_word = status_word;
    s.fsd = fsd;
    // Lock held for the whole table
    s.locked = 1'b1;
    s.exp_p1 = exp_p1;
    s.exp_p2 = exp_p2;
    s.exp_arx = exp_arx;
    s.exp_ary = exp_ary;
    s.exp_sl = exp_sl;
    s.exp_sd = exp_sd;
    s.exp_hq = exp_hq;
    s.wait_cycles = 1;
    steps.push_back(s);
  endtask

  ////////////////////////////////////////
  // Compare tasks
  ////////////////////////////////////////

  task automatic check_ctrl(input string name, input logic [CTRL_W-1:0] got,
                            input logic [CTRL_W-1:0] exp);
    checks++;
    if (got !== exp) begin
      errors++;
      $display("CHECK FAILED %s: got 0x%h, expected 0x%h", name, got, exp);
    end
  endtask

  task automatic check_aspect(input string name, input logic [ARX_W-1:0] got,
                              input logic [ARX_W-1:0] exp);
    checks++;
    if (got !== exp) begin
      errors++;
      $display("CHECK FAILED %s: got 0x%h, expected 0x%h", name, got, exp);
    end
  endtask

  task automatic check_level(input string name, input logic [SL_W-1:0] got,
                             input logic [SL_W-1:0] exp);
    checks++;
    if (got !== exp) begin
      errors++;
      $display("CHECK FAILED %s: got 0x%h, expected 0x%h", name, got, exp);
    end
  endtask

  task automatic check_flag(input string name, input logic got, input logic exp);
    checks++;
    if (got !== exp) begin
      errors++;
      $display("CHECK FAILED %s: got 0x%h, expected 0x%h", name, got, exp);
    end
  endtask

  task automatic check_video(input logic [ARX_W-1:0] arx, input logic [ARX_W-1:0] ary,
                             input logic [SL_W-1:0] sl, input logic sd, input logic hq);
    check_aspect("video_arx", video_arx, arx);
    check_aspect("video_ary", video_ary, ary);
    check_level("vga_sl", vga_sl, sl);
    check_flag("scandoubler", scandoubler, sd);
    check_flag("hq2x", hq2x, hq);
  endtask

  // One line per finished test
  task automatic report_test(input string name, input int errors_before);
    tests++;
    if (errors == errors_before) begin
      passed++;
      $display("test %-24s ok", name);
    end else begin
      $display("test %-24s %0d errors", name, errors - errors_before);
    end
  endtask

  ////////////////////////////////////////
  // Main sequence
  ////////////////////////////////////////

  initial begin
    logic [JOY_W-1:0]  rand_j0;
    logic [JOY_W-1:0]  rand_j1;
    logic [CTRL_W-1:0] up_bit;
    logic [PS2_W-1:0]  r_released;
    int                table_cycles;
    int                errors_before;
    int                rise_cycles;
    int                high_cycles;

    RESET = 1'b1;
    ps2_key = '0;
    joystick_0 = '0;
    joystick_1 = '0;
    status = '0;
    forced_scandoubler = 1'b0;
    pll_locked = 1'b0;

    void'($urandom(32'hf0ae_880e));
    rand_j0 = $urandom();
    rand_j1 = $urandom();
    // Up bit left clear so the held key R shows through the OR
    rand_j1[CTRL_UP] = 1'b0;
    up_bit = ctrl_bit(CTRL_UP);
    r_released = key_word(1'b0, 1'b0, KEY_R);

    // Key press, stale word, release
    add_step("key up press", key_word(1'b1, 1'b1, KEY_UP), '0, '0, '0, 1'b0,
             up_bit, '0, 12'd4, 12'd3, 2'd0, 1'b0, 1'b0);
    add_step("key no toggle", key_word(1'b1, 1'b0, KEY_UP), '0, '0, '0, 1'b0,
             up_bit, '0, 12'd4, 12'd3, 2'd0, 1'b0, 1'b0);
    add_step("key up release", key_word(1'b0, 1'b0, KEY_UP), '0, '0, '0, 1'b0,
             '0, '0, 12'd4, 12'd3, 2'd0, 1'b0, 1'b0);
    // Joystick ORed with held player 2 key
    add_step("joy 1 with key r", key_word(1'b1, 1'b1, KEY_R), '0, rand_j1, '0, 1'b0,
             '0, rand_j1[CTRL_W-1:0] | up_bit, 12'd4, 12'd3, 2'd0, 1'b0, 1'b0);
    add_step("joy 0 key r only", key_word(1'b1, 1'b1, KEY_R), rand_j0, '0, '0, 1'b0,
             rand_j0[CTRL_W-1:0], up_bit, 12'd4, 12'd3, 2'd0, 1'b0, 1'b0);
    add_step("key r release", r_released, '0, '0, '0, 1'b0,
             '0, '0, 12'd4, 12'd3, 2'd0, 1'b0, 1'b0);
    // Video option decode
    add_step("aspect rotated", r_released, '0, '0, option_word(2'd0, 1'b1, 3'd0), 1'b0,
             '0, '0, 12'd3, 12'd4, 2'd0, 1'b0, 1'b0);
    add_step("aspect 3", r_released, '0, '0, option_word(2'd3, 1'b0, 3'd0), 1'b0,
             '0, '0, 12'd2, 12'd0, 2'd0, 1'b0, 1'b0);
    add_step("fx hq2x", r_released, '0, '0, option_word(2'd0, 1'b0, 3'd1), 1'b0,
             '0, '0, 12'd4, 12'd3, 2'd0, 1'b1, 1'b1);
    add_step("fx scanline 3", r_released, '0, '0, option_word(2'd0, 1'b0, 3'd4), 1'b0,
             '0, '0, 12'd4, 12'd3, 2'd3, 1'b1, 1'b0);
    add_step("forced scandoubler", r_released, '0, '0, '0, 1'b1,
             '0, '0, 12'd4, 12'd3, 2'd0, 1'b1, 1'b0);

    // Limit from reset, table rows and margin
    table_cycles = RESET_CYCLES + 1;
    foreach (steps[i]) begin
      table_cycles += 2 + steps[i].wait_cycles;
    end
    cycle_limit = table_cycles + MARGIN_CYCLES;

    // Reset over the first rising edges
    repeat (RESET_CYCLES) @(posedge clk_sys);
    @(negedge clk_sys);
    RESET = 1'b0;
    @(negedge clk_sys);
    errors_before = errors;
    check_ctrl("player_1_ctrl", player_1_ctrl, '0);
    check_ctrl("player_2_ctrl", player_2_ctrl, '0);
    check_flag("pll_reset", pll_reset, 1'b0);
    check_video(12'd4, 12'd3, 2'd0, 1'b0, 1'b0);
    report_test("reset state", errors_before);

    // Table rows start on a falling edge
    foreach (steps[i]) begin
      ps2_key = steps[i].ps2_word;
      joystick_0 = steps[i].joy_0;
      joystick_1 = steps[i].joy_1;
      status = steps[i].status_word;
      forced_scandoubler = steps[i].fsd;
      pll_locked = steps[i].locked;
      repeat (2) @(negedge clk_sys);
      errors_before = errors;
      check_ctrl("player_1_ctrl", player_1_ctrl, steps[i].exp_p1);
      check_ctrl("player_2_ctrl", player_2_ctrl, steps[i].exp_p2);
      check_video(steps[i].exp_arx, steps[i].exp_ary, steps[i].exp_sl,
                  steps[i].exp_sd, steps[i].exp_hq);
      check_flag("pll_reset", pll_reset, 1'b0);
      report_test(steps[i].name, errors_before);
      repeat (steps[i].wait_cycles) @(negedge clk_sys);
    end

    ////////////////////////////////////////
    // Lock loss
    ////////////////////////////////////////

    errors_before = errors;
    pll_locked = 1'b0;
    rise_cycles = 0;
    do begin
      @(negedge clk_sys);
      rise_cycles++;
    end while (!pll_reset && rise_cycles < 2);
    check_flag("pll_reset", pll_reset, 1'b1);

    // Width of the stretched reset
    high_cycles = 0;
    while (pll_reset && high_cycles < LOCK_MAX_CYCLES) begin
      @(negedge clk_sys);
      high_cycles++;
    end
    if (high_cycles < LOCK_RESET_CYCLES) begin
      errors++;
      $display("pll_reset fell after only %0d cycles, at least %0d were due",
               high_cycles, LOCK_RESET_CYCLES);
    end
    check_flag("pll_reset", pll_reset, 1'b0);
    report_test("lock loss", errors_before);

    $display("tests %0d, passed %0d, checks %0d, errors %0d", tests, passed, checks, errors);
    if (errors == 0) begin
      $display("Simulation completed successfully");
    end else begin
      $display("Simulation failed");
    end
    $finish;
  end

endmodule

//--- verilog.f
src/arcade_pkg.sv
src/ps2_key_tracker.sv
src/player_merge.sv
src/video_option_decode.sv
src/lock_loss_reset.sv
src/arcade_front_end.sv
testbench/arcade_front_end_assertions.sv
testbench/arcade_front_end_tb.sv

//--- run.sh
#!/bin/sh
# Build and run with Verilator; a build error or abnormal exit also counts as failure
cd "$(dirname "$0")" || exit 1
rm -rf obj_dir sim.log
verilator --binary --timing --assert --timescale 1ns/1ps --top-module arcade_front_end_tb \
  -f verilog.f -o arcade_sim > sim.log 2>&1 &&
  ./obj_dir/arcade_sim >> sim.log 2>&1 ||
  echo "Simulation failed" >> sim.log
cat sim.log
grep -q "Simulation failed" sim.log && exit 1 || exit 0
